/* logic/exu_pkg.sv */
package exu_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int XLEN       = 32;              // Data and address word
  localparam int DMEM_WORDS = 64;              // Data memory depth
  localparam int DMEM_AW    = 6;               // Word index width
  localparam logic [7:0] DMEM_LFSR_SEED = 8'hA5; // Wait-cycle generator start

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [XLEN-1:0]    word_t;     // Data or address word
  typedef logic [4:0]         reg_idx_t;  // Destination register number
  typedef logic [DMEM_AW-1:0] dmem_idx_t; // Word index into data memory

  // Operation codes from decode
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    LW,
    SW
  } exu_op_e;

  // Branch class for the control FSM
  typedef enum logic [1:0] {
    ALU,
    LOAD,
    STORE
  } inst_type_e;

  // Control FSM states, same order as the bus sequence
  typedef enum logic [2:0] {
    IDLE,
    WAIT_ARREADY,   // AR channel
    WAIT_RVALID,    // R channel
    WAIT_AWREADY,   // AW channel
    WAIT_WREADY,    // W channel
    WAIT_BVALID,    // B channel
    WAIT_READY      // Result offered to writeback
  } exu_state_e;

  // --------------------------------------------------------------------------
  // Bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    exu_op_e  op;
    reg_idx_t rd;
    word_t    src1;
    word_t    src2;
    word_t    imm;
  } exu_req_t;                                 // 104 bits

  typedef struct packed {
    reg_idx_t rd;
    logic     wen;
    word_t    data;
  } exu_res_t;                                 // 38 bits

  typedef struct packed {
    word_t addr;                               // Byte address
    word_t wdata;                              // Store data
  } mem_req_t;                                 // 64 bits

endpackage

/* logic/exu_issue.sv */
`timescale 1ns/1ns

module exu_issue import exu_pkg::*; (
  input  logic       clk,
  input  logic       rst,          // Active low, async

  // Decode side
  input  exu_req_t   req_i,        // Incoming operation
  input  logic       accept_i,     // valid_pre and ready_pre

  // Toward FSM, ALU and writeback
  output inst_type_e inst_type_o,  // Class of the incoming op
  output exu_req_t   op_o          // Held copy of the accepted op
);

  exu_req_t op_q;

  // --------------------------------------------------------------------------
  // Classify incoming opcode
  // --------------------------------------------------------------------------
  // Looks at req_i directly, not the held copy, because the FSM
  // picks its branch in the same cycle as accept
  always_comb begin
    unique case (req_i.op)
      LW:      inst_type_o = LOAD;
      SW:      inst_type_o = STORE;
      ADD,
      SUB,
      AND,
      OR,
      XOR:     inst_type_o = ALU;
      default: inst_type_o = ALU;          // Unused codes run as ALU
    endcase
  end

  // --------------------------------------------------------------------------
  // Operation register
  // --------------------------------------------------------------------------
  // Loaded on accept only; later states see a stable copy while the
  // decode side is free to move on
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      op_q <= '0;
    end else if (accept_i) begin
      op_q <= req_i;
    end
  end

  assign op_o = op_q;

endmodule

/* logic/exu_alu.sv */
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
  input  exu_req_t op_i,       // Held operation from issue
  output word_t    result_o,   // ALU result
  output mem_req_t mem_o       // Address and store data
);

  word_t a;
  word_t b;
  word_t sum;
  word_t diff;

  // Operand aliases
  assign a = op_i.src1;
  assign b = op_i.src2;

  assign sum  = a + b;
  assign diff = a - b;

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (op_i.op)
      ADD:     result_o = sum;
      SUB:     result_o = diff;
      AND:     result_o = a & b;
      OR:      result_o = a | b;
      XOR:     result_o = a ^ b;
      LW,
      SW:      result_o = '0;          // Result comes from memory or is empty
      default: result_o = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Memory request
  // --------------------------------------------------------------------------
  // Effective address is base plus offset, no alignment check
  assign mem_o.addr  = op_i.src1 + op_i.imm;

  // Store data is always the second register
  assign mem_o.wdata = op_i.src2;

endmodule

/* logic/exu_fsm.sv */
`timescale 1ns/1ns

module exu_fsm import exu_pkg::*; (
  input  logic       clk,
  input  logic       rst,            // Active low, async

  // Decode side
  input  inst_type_e inst_type_i,    // Class of the incoming op
  input  logic       valid_pre_i,
  output logic       ready_pre_o,
  output logic       accept_o,       // Transfer on the decode pair

  // Writeback side
  output logic       valid_post_o,
  input  logic       ready_post_i,

  // AR channel
  output logic       arvalid_o,
  input  logic       arready_i,

  // R channel
  input  logic       rvalid_i,
  output logic       rready_o,

  // AW channel
  output logic       awvalid_o,
  input  logic       awready_i,

  // W channel
  output logic       wvalid_o,
  input  logic       wready_i,

  // B channel
  input  logic       bvalid_i,
  output logic       bready_o
);

  exu_state_e state_q;
  exu_state_e state_d;

  // --------------------------------------------------------------------------
  // Outputs, decoded from state only
  // --------------------------------------------------------------------------
  assign ready_pre_o  = (state_q == IDLE);
  assign valid_post_o = (state_q == WAIT_READY);

  assign arvalid_o    = (state_q == WAIT_ARREADY);   // AR
  assign rready_o     = (state_q == WAIT_RVALID);    // R

  assign awvalid_o    = (state_q == WAIT_AWREADY);   // AW
  assign wvalid_o     = (state_q == WAIT_WREADY);    // W
  assign bready_o     = (state_q == WAIT_BVALID);    // B

  // Decode pair handshake
  assign accept_o = valid_pre_i && ready_pre_o;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;                         // Hold by default
    unique case (state_q)
      IDLE: begin
        if (valid_pre_i) begin
          unique case (inst_type_i)
            LOAD:    state_d = WAIT_ARREADY;   // Read path
            STORE:   state_d = WAIT_AWREADY;   // Write path
            default: state_d = WAIT_READY;     // ALU result ready next cycle
          endcase
        end
      end
      WAIT_ARREADY: if (arready_i)    state_d = WAIT_RVALID;
      WAIT_RVALID:  if (rvalid_i)     state_d = WAIT_READY;
      WAIT_AWREADY: if (awready_i)    state_d = WAIT_WREADY;
      WAIT_WREADY:  if (wready_i)     state_d = WAIT_BVALID;
      WAIT_BVALID:  if (bvalid_i)     state_d = WAIT_READY;
      WAIT_READY:   if (ready_post_i) state_d = IDLE;
      default:                        state_d = IDLE;   // Illegal code recovers
    endcase
  end

endmodule

/* logic/exu_dmem.sv */
`timescale 1ns/1ns

module exu_dmem import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,          // Active low, async
  input  mem_req_t mem_i,        // Address and store data from ALU
  input  logic     arvalid_i,
  output logic     arready_o,
  output logic     rvalid_o,
  input  logic     rready_i,
  output word_t    rdata_o,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  logic     wvalid_i,
  output logic     wready_o,
  output logic     bvalid_o,
  input  logic     bready_i
);

  logic [7:0] lfsr_q;                  // Wait-cycle generator
  word_t      mem_q [DMEM_WORDS];
  word_t      rdata_q;
  dmem_idx_t  idx;                     // Word index, wraps modulo depth
  dmem_idx_t  aw_idx_q;                // Write index latched on AW
  logic       arready_q, rvalid_q, awready_q, wready_q, bvalid_q;
  logic       b_pend_q;                // W done, response owed
  logic       ar_xfer, r_xfer, aw_xfer, w_xfer, b_xfer;

  assign idx = mem_i.addr[DMEM_AW+1:2];  // Drop byte offset

  // Channel transfers
  assign ar_xfer = arvalid_i && arready_q;
  assign r_xfer  = rvalid_q  && rready_i;
  assign aw_xfer = awvalid_i && awready_q;
  assign w_xfer  = wvalid_i  && wready_q;
  assign b_xfer  = bvalid_q  && bready_i;

  // --------------------------------------------------------------------------
  // Handshake and wait cycles
  // --------------------------------------------------------------------------
  // Each ready or response is registered, so it lags its valid level by
  // one cycle at least; an LFSR bit adds further random wait cycles
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lfsr_q    <= DMEM_LFSR_SEED;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      b_pend_q  <= 1'b0;
      aw_idx_q  <= '0;
      rdata_q   <= '0;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]}; // Max length

      if (ar_xfer)                                arready_q <= 1'b0; // One pulse
      else if (arvalid_i && lfsr_q[0])            arready_q <= 1'b1;
      if (r_xfer)                                 rvalid_q  <= 1'b0;
      else if (rready_i && lfsr_q[1])             rvalid_q  <= 1'b1;
      if (aw_xfer)                                awready_q <= 1'b0;
      else if (awvalid_i && lfsr_q[2])            awready_q <= 1'b1;
      if (w_xfer)                                 wready_q  <= 1'b0;
      else if (wvalid_i && lfsr_q[3])             wready_q  <= 1'b1;
      if (b_xfer)                                 bvalid_q  <= 1'b0; // Held until bready
      else if (bready_i && b_pend_q && lfsr_q[4]) bvalid_q  <= 1'b1;

      if (w_xfer)      b_pend_q <= 1'b1;
      else if (b_xfer) b_pend_q <= 1'b0;

      if (ar_xfer) rdata_q  <= mem_q[idx];   // Read data fixed at AR
      if (aw_xfer) aw_idx_q <= idx;
    end
  end

  // --------------------------------------------------------------------------
  // Storage, cleared on reset, written on W transfer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DMEM_WORDS; i++) mem_q[i] <= '0;
    end else if (w_xfer) begin
      mem_q[aw_idx_q] <= mem_i.wdata;
    end
  end

  assign arready_o = arready_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign bvalid_o  = bvalid_q;

endmodule

/* logic/exu_wb.sv */
`timescale 1ns/1ns

module exu_wb import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,            // Active low, async
  input  exu_req_t op_i,           // Held operation
  input  word_t    alu_result_i,
  input  word_t    rdata_i,        // Read data from memory
  input  logic     rvalid_i,
  input  logic     rready_i,
  output exu_res_t res_o           // Writeback result
);

  word_t load_q;                   // Captured load data

  // --------------------------------------------------------------------------
  // Load data capture on R transfer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      load_q <= '0;
    end else if (rvalid_i && rready_i) begin
      load_q <= rdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  // All sources are registered, so res_o holds still in WAIT_READY
  always_comb begin
    res_o.rd = op_i.rd;
    unique case (op_i.op)
      LW: begin
        res_o.wen  = 1'b1;
        res_o.data = load_q;
      end
      SW: begin
        res_o.wen  = 1'b0;             // Store writes no register
        res_o.data = '0;
      end
      default: begin
        res_o.wen  = 1'b1;             // ALU ops
        res_o.data = alu_result_i;
      end
    endcase
  end

endmodule

/* logic/exu_top.sv */
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,            // Active low, async

  // Decode side
  input  exu_req_t req_i,
  input  logic     valid_pre_i,
  output logic     ready_pre_o,

  // Writeback side
  output exu_res_t res_o,
  output logic     valid_post_o,
  input  logic     ready_post_i
);

  // --------------------------------------------------------------------------
  // Internal wires
  // --------------------------------------------------------------------------
  inst_type_e inst_type;
  exu_req_t   op;              // Held operation
  logic       accept;
  word_t      alu_result;
  mem_req_t   mem_req;
  word_t      rdata;

  // AXI-lite style handshakes
  logic arvalid, arready;
  logic rvalid, rready;
  logic awvalid, awready;
  logic wvalid, wready;
  logic bvalid, bready;

  // Input side
  exu_issue u_issue (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .accept_i    (accept),
    .inst_type_o (inst_type),
    .op_o        (op)
  );

  exu_alu u_alu (
    .op_i     (op),
    .result_o (alu_result),
    .mem_o    (mem_req)
  );

  // Control
  exu_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .inst_type_i  (inst_type),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .accept_o     (accept),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .rvalid_i     (rvalid),
    .rready_o     (rready),
    .awvalid_o    (awvalid),
    .awready_i    (awready),
    .wvalid_o     (wvalid),
    .wready_i     (wready),
    .bvalid_i     (bvalid),
    .bready_o     (bready)
  );

  // Data memory slave
  exu_dmem u_dmem (
    .clk       (clk),
    .rst       (rst),
    .mem_i     (mem_req),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bready_i  (bready)
  );

  // Output side
  exu_wb u_wb (
    .clk          (clk),
    .rst          (rst),
    .op_i         (op),
    .alu_result_i (alu_result),
    .rdata_i      (rdata),
    .rvalid_i     (rvalid),
    .rready_i     (rready),
    .res_o        (res_o)
  );

endmodule

/* verif/exu_tb_clk.sv */
`timescale 1ns/1ns

module exu_tb_clk (
  output logic clk_o,              // 100 ns period
  output logic rst_o               // Active low
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release just after an edge, same as stimulus
  initial begin
    rst_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b1;
  end

endmodule

/* verif/exu_tb.sv */
`timescale 1ns/1ns

module exu_tb import exu_pkg::*; ();

  localparam int          NUM_OPS        = 400;
  localparam int          TIMEOUT_CYCLES = NUM_OPS * 40;
  localparam int unsigned SEED           = 32'hd5d9_3e85;

  logic     clk;
  logic     rst;
  exu_req_t req_i;
  logic     valid_pre_i;
  logic     ready_pre_o;
  exu_res_t res_o;
  logic     valid_post_o;
  logic     ready_post_i;

  word_t    model_mem [DMEM_WORDS];    // Reference copy of data memory
  exu_res_t exp_q [$];                 // Expected results in arrival order
  exu_res_t held_res;                  // res_o seen under back-pressure
  int       n_acc;
  int       n_done;
  int       cycles;
  logic     alu_due;                   // ALU result owed next cycle
  logic     hold_pending;
  logic     wb_last;                   // Writeback on previous edge

  exu_tb_clk u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  exu_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .res_o        (res_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i)
  );

  // --------------------------------------------------------------------------
  // Failure, reference model and stimulus helpers
  // --------------------------------------------------------------------------
  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("FAIL %0t ns %s: got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  // Applies one op to the model memory, returns its writeback
  function automatic exu_res_t ref_result(input exu_req_t req);
    exu_res_t    res;
    word_t       addr;
    int unsigned idx;
    addr     = req.src1 + req.imm;
    idx      = (addr >> 2) % DMEM_WORDS;     // Word index wraps at depth
    res.rd   = req.rd;
    res.wen  = 1'b1;
    res.data = '0;
    case (req.op)
      ADD:     res.data = req.src1 + req.src2;
      SUB:     res.data = req.src1 - req.src2;
      AND:     res.data = req.src1 & req.src2;
      OR:      res.data = req.src1 | req.src2;
      XOR:     res.data = req.src1 ^ req.src2;
      LW:      res.data = model_mem[idx];
      SW: begin
        model_mem[idx] = req.src2;
        res.wen        = 1'b0;             // Empty result
      end
      default: res.data = '0;
    endcase
    return res;
  endfunction

  function automatic exu_req_t make_req();
    exu_req_t    r;
    int unsigned pick;
    dmem_idx_t   target;
    pick   = $urandom_range(9);
    target = dmem_idx_t'($urandom_range(DMEM_WORDS - 1));
    if (pick < 5) r.op = exu_op_e'(pick[2:0]); // Five ALU ops
    else if (pick < 8) r.op = LW;
    else r.op = SW;
    r.rd   = reg_idx_t'($urandom_range(31));
    r.src1 = $urandom;
    r.src2 = $urandom;
    r.imm  = $urandom;
    if (r.op == LW || r.op == SW) begin
      // Aligned word address plus random upper bits that wrap away
      r.imm = (word_t'($urandom) << 8) + {24'b0, target, 2'b00} - r.src1;
    end
    return r;
  endfunction

  task automatic drive_ready_post();
    forever begin
      @(posedge clk);
      #1 ready_post_i = ($urandom_range(99) >= 30);  // Low 30 % of cycles
    end
  endtask

  task automatic send_op(input exu_req_t req);
    repeat ($urandom_range(2)) begin         // Idle gap
      @(posedge clk);
      #1;
    end
    req_i       = req;
    valid_pre_i = 1'b1;
    @(negedge clk);
    while (!ready_pre_o) @(negedge clk);     // Transfer on next edge
    @(posedge clk);
    #1 valid_pre_i = 1'b0;
    req_i.src1 = $urandom;                   // DUT must use its held copy
    req_i.src2 = $urandom;
    req_i.imm  = $urandom;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and end of run
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    req_i        = '0;
    valid_pre_i  = 1'b0;
    ready_post_i = 1'b0;
    for (int i = 0; i < DMEM_WORDS; i++) model_mem[i] = '0;
    fork
      drive_ready_post();                    // Inherits the seeded generator
    join_none
    @(posedge rst);
    @(negedge clk);
    assert (ready_pre_o && !valid_post_o) else begin
      $display("Error at %0t ns: handshake outputs wrong after reset", $time);
      fail_run();
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_OPS; i++) send_op(make_req());
    while (n_done < NUM_OPS) @(posedge clk);
    repeat (2) @(posedge clk);               // Room for a stray result after the last one
    #1;
    if (n_done == NUM_OPS && exp_q.size() == 0 && !valid_post_o) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Error: %0d accepted, %0d written back, result offered after the last one %b",
               n_acc, n_done, valid_post_o);
      fail_run();
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        fail_run();
      end
    end
  end

  // --------------------------------------------------------------------------
  // Compare mid-cycle where all signals are settled
  // --------------------------------------------------------------------------
  initial begin
    exu_res_t exp;
    n_acc        = 0;
    n_done       = 0;
    alu_due      = 1'b0;
    hold_pending = 1'b0;
    wb_last      = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        if (alu_due) begin
          assert (valid_post_o) else begin
            $display("Error at %0t ns: ALU result not offered one cycle after accept", $time);
            fail_run();
          end
        end
        if (hold_pending) begin               // Result frozen while stalled
          assert (valid_post_o) else begin
            $display("Error at %0t ns: valid_post_o dropped without a transfer", $time);
            fail_run();
          end
          assert (res_o == held_res) else begin
            $display("FAIL %0t ns res_o: got %h expected %h", $time, res_o, held_res);
            fail_run();
          end
        end
        if (wb_last) begin
          assert (ready_pre_o) else begin
            $display("Error at %0t ns: ready_pre_o low after writeback", $time);
            fail_run();
          end
        end
        if (valid_post_o) begin
          assert (!ready_pre_o) else begin
            $display("Error at %0t ns: ready_pre_o high while a result waits", $time);
            fail_run();
          end
        end
        alu_due      = 1'b0;
        hold_pending = 1'b0;
        wb_last      = 1'b0;

        if (valid_pre_i && ready_pre_o) begin  // Accept on next edge
          exp_q.push_back(ref_result(req_i));
          n_acc++;
          alu_due = (req_i.op != LW) && (req_i.op != SW);
        end

        if (valid_post_o && ready_post_i) begin
          assert (exp_q.size() > 0) else begin
            $display("Error at %0t ns: writeback with no operation pending", $time);
            fail_run();
          end
          exp = exp_q.pop_front();
          check_word("res_o.rd",   word_t'(res_o.rd),  word_t'(exp.rd));
          check_word("res_o.wen",  word_t'(res_o.wen), word_t'(exp.wen));
          check_word("res_o.data", res_o.data,         exp.data);
          n_done++;
          wb_last = 1'b1;
        end else if (valid_post_o) begin       // Back-pressure
          hold_pending = 1'b1;
          held_res     = res_o;
        end
      end
    end
  end

endmodule

/* vlog.f */
logic/exu_pkg.sv
logic/exu_issue.sv
logic/exu_alu.sv
logic/exu_fsm.sv
logic/exu_dmem.sv
logic/exu_wb.sv
logic/exu_top.sv
verif/exu_tb_clk.sv
verif/exu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exu_tb \
  -f vlog.f -o exu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/exu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation passed"
exit 0
